/* files.f */
+incdir+hw
hw/irq_pkg.sv
hw/irq_pending_reg.sv
hw/irq_arbiter.sv
hw/sleep_timer.sv
hw/sleep_fsm.sv
hw/irq_sleep_top.sv
test/tb_irq_sleep.sv

/* hw/irq_arbiter.sv */
// Fixed-priority interrupt arbiter issuing a one-cycle acknowledge with the winner id
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_arbiter (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Pending and enabled interrupts
  input  wire irq_pkg::irq_vec_t  pend_en_i,
  // Current privilege level of the core
  input  wire irq_pkg::priv_lvl_e priv_lvl_i,
  // Global machine interrupt enable
  input  wire logic               mstatus_mie_i,
  output logic                    irq_ack_o,
  output irq_pkg::irq_id_t        irq_id_o
);

  import irq_pkg::*;

  localparam irq_vec_t valid_mask = `IRQ_VALID_MASK;

  irq_id_t win_id;
  logic    win_valid;
  logic    any_pend;
  logic    permit;

  // ------------------------------
  // Winner selection
  // ------------------------------
  // Lowest priority is written first so later matches override
  // Order high to low: 31..16, 11, 3, 7
  always_comb begin
    win_id    = '0;
    win_valid = 1'b0;
    if (pend_en_i[7]) begin
      win_id    = irq_id_t'(7);
      win_valid = 1'b1;
    end
    if (pend_en_i[3]) begin
      win_id    = irq_id_t'(3);
      win_valid = 1'b1;
    end
    if (pend_en_i[11]) begin
      win_id    = irq_id_t'(11);
      win_valid = 1'b1;
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en_i[i]) begin
        win_id    = irq_id_t'(i);
        win_valid = 1'b1;
      end
    end
  end

  // ------------------------------
  // Permission rule
  // ------------------------------
  assign any_pend = |pend_en_i;

  // M-mode needs the global enable, U-mode takes any enabled interrupt
  assign permit = ((priv_lvl_i == PRIV_M) && mstatus_mie_i) ||
                  ((priv_lvl_i == PRIV_U) && any_pend);

  // Ack pulse register, id holds between acknowledges
  // Low for one cycle after each ack, so a held line acks every other cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_o <= 1'b0;
      irq_id_o  <= '0;
    end else if (win_valid && permit && !irq_ack_o) begin
      irq_ack_o <= 1'b1;
      irq_id_o  <= win_id;
    end else begin
      irq_ack_o <= 1'b0;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) irq_ack_o |=> !irq_ack_o
  ) else $error("irq_ack_o held for more than one cycle");

  a_ack_id_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) irq_ack_o |-> valid_mask[irq_id_o]
  ) else $error("irq_id_o %0d is a reserved position", irq_id_o);

  // Acked line was pending and enabled when the ack was registered
  a_ack_id_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> |((irq_vec_t'(1) << irq_id_o) & $past(pend_en_i))
  ) else $error("irq_id_o %0d was not enabled in the previous cycle", irq_id_o);

endmodule

`default_nettype wire

/* hw/irq_params.svh */
// Shared constants for the interrupt and sleep controller, included by RTL and testbench
`ifndef IRQ_PARAMS_SVH
`define IRQ_PARAMS_SVH

// ------------------------------
// Interrupt lines
// ------------------------------
// One bit per line of the core interrupt input
`define IRQ_NUM 32
// Real interrupts: 31..16 platform, 11 external, 7 timer, 3 software
`define IRQ_VALID_MASK 32'hffff_0888
// Enough bits to name any of the 32 lines
`define IRQ_ID_W 5

// ------------------------------
// Sleep sequencing
// ------------------------------
// Consecutive drained cycles before the core may sleep
`define SLEEP_LATENCY 2
`define SLEEP_CNT_W 2
// Fetch buffer outstanding transaction count
`define OUTSTANDING_W 2

`endif

/* hw/irq_pending_reg.sv */
// Machine-pending register: samples the raw interrupt lines and forms pending-enabled
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_pending_reg (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // Raw interrupt lines from the platform
  input  wire irq_pkg::irq_vec_t irq_i,
  // Machine interrupt enable CSR
  input  wire irq_pkg::irq_vec_t mie_i,
  // Machine interrupt pending CSR
  output irq_pkg::irq_vec_t      mip_o,
  // Pending and enabled, feeds arbiter and wake logic
  output irq_pkg::irq_vec_t      pend_en_o
);

  import irq_pkg::*;

  // Positions that hold a real interrupt
  localparam irq_vec_t valid_mask = `IRQ_VALID_MASK;

  // ------------------------------
  // Pending register
  // ------------------------------
  // Reserved positions never latch, whatever the raw line does
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_o <= '0;
    end else begin
      mip_o <= irq_i & valid_mask;
    end
  end

  // Combinational so the enable CSR acts in the same cycle
  assign pend_en_o = mip_o & mie_i;

  // ------------------------------
  // Checks
  // ------------------------------
  // Reserved positions never show in the pending register
  a_mip_reserved_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~valid_mask) == '0
  ) else begin
    $error("mip_o 0x%08x has a reserved bit set", mip_o);
  end

endmodule

`default_nettype wire

/* hw/irq_pkg.sv */
// Types shared by the interrupt and sleep controller blocks, imported where used
`default_nettype none

`include "irq_params.svh"

package irq_pkg;

  // ------------------------------
  // Vector and count types
  // ------------------------------
  // Raw lines, pending, enable and pending-enabled vectors
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;
  // Number of one interrupt line
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;
  // Drained-cycle counter
  typedef logic [`SLEEP_CNT_W-1:0] sleep_cnt_t;
  // Outstanding instruction fetches
  typedef logic [`OUTSTANDING_W-1:0] outstanding_t;

  // ------------------------------
  // Enums
  // ------------------------------
  // Privilege encodings as in the mstatus MPP field
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Wait-for-interrupt sequencer states
  typedef enum logic [1:0] {
    ST_RUN   = 2'b00,
    ST_DRAIN = 2'b01,
    ST_SLEEP = 2'b10
  } sleep_state_e;

endpackage

`default_nettype wire

/* hw/irq_sleep_top.sv */
// Top level of the interrupt and sleep controller, wires pending, arbiter and sleep blocks
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Interrupt side
  input  wire irq_pkg::irq_vec_t     irq_i,
  input  wire irq_pkg::irq_vec_t     mie_i,
  input  wire irq_pkg::priv_lvl_e    priv_lvl_i,
  input  wire logic                  mstatus_mie_i,
  // Sleep side
  input  wire logic                  wfi_i,
  input  wire logic                  lsu_busy_i,
  input  wire irq_pkg::outstanding_t outstanding_i,
  input  wire logic                  debug_req_i,
  input  wire logic                  nmi_pending_i,
  // Outputs
  output logic                       core_sleep_o,
  output logic                       in_wfi_o,
  output irq_pkg::irq_vec_t          mip_o,
  output logic                       irq_ack_o,
  output irq_pkg::irq_id_t           irq_id_o
);

  import irq_pkg::*;

  // ------------------------------
  // Internal nets
  // ------------------------------
  irq_vec_t pend_en;
  logic     cnt_en;
  logic     lat_done;

  // Pending register, one cycle from lines to mip
  irq_pending_reg i_irq_pending_reg (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .mie_i     (mie_i),
    .mip_o     (mip_o),
    .pend_en_o (pend_en)
  );

  // Arbiter, ack registered one more cycle on
  irq_arbiter i_irq_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pend_en_i     (pend_en),
    .priv_lvl_i    (priv_lvl_i),
    .mstatus_mie_i (mstatus_mie_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  // Sequencer reduces the pending-enabled vector to its own wake reason
  sleep_fsm i_sleep_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wfi_i         (wfi_i),
    .lsu_busy_i    (lsu_busy_i),
    .outstanding_i (outstanding_i),
    .debug_req_i   (debug_req_i),
    .nmi_pending_i (nmi_pending_i),
    .irq_wake_i    (pend_en),
    .lat_done_i    (lat_done),
    .cnt_en_o      (cnt_en),
    .core_sleep_o  (core_sleep_o),
    .in_wfi_o      (in_wfi_o)
  );

  // Drain latency counter
  sleep_timer i_sleep_timer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cnt_en_i   (cnt_en),
    .lat_done_o (lat_done)
  );

endmodule

`default_nettype wire

/* hw/sleep_fsm.sv */
// Wait-for-interrupt sequencer: run, drain, sleep and wake on any wake reason
`timescale 1ns/1ps
`default_nettype none

module sleep_fsm (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Retired legal wait instruction, one strobe
  input  wire logic                  wfi_i,
  // Load-store unit still has a transfer in flight
  input  wire logic                  lsu_busy_i,
  // Fetch buffer outstanding transactions
  input  wire irq_pkg::outstanding_t outstanding_i,
  input  wire logic                  debug_req_i,
  // NMI pending and allowed
  input  wire logic                  nmi_pending_i,
  // Pending-enabled vector, any bit wakes
  input  wire irq_pkg::irq_vec_t     irq_wake_i,
  // Drain latency reached
  input  wire logic                  lat_done_i,
  output logic                       cnt_en_o,
  output logic                       core_sleep_o,
  output logic                       in_wfi_o
);

  import irq_pkg::*;

  sleep_state_e state_q;
  sleep_state_e state_d;
  logic         wake;
  logic         drained;

  // ------------------------------
  // Wake and drain conditions
  // ------------------------------
  assign wake = (|irq_wake_i) || debug_req_i || nmi_pending_i;

  // Pipeline idle and nothing asking to wake
  assign drained = (outstanding_i == '0) && !lsu_busy_i && !wake;

  // Timer counts only consecutive drained cycles while draining
  assign cnt_en_o = (state_q == ST_DRAIN) && drained;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: begin
        if (wfi_i) begin
          state_d = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        // Wake has priority, a drained cycle already excludes it
        if (wake) begin
          state_d = ST_RUN;
        end else if (drained && lat_done_i) begin
          state_d = ST_SLEEP;
        end
      end
      ST_SLEEP: begin
        if (wake) begin
          state_d = ST_RUN;
        end
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Decoded straight from the state register
  assign core_sleep_o = (state_q == ST_SLEEP);
  assign in_wfi_o     = (state_q == ST_DRAIN) || (state_q == ST_SLEEP);

  // ------------------------------
  // Checks
  // ------------------------------
  // Sleep is only ever entered from a wait in progress
  a_sleep_in_wfi: assert property (
    @(posedge clk_i) disable iff (!rst_ni) core_sleep_o |-> $past(in_wfi_o)
  ) else $error("core_sleep_o high without a preceding wait");

  a_wake_ends_sleep: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (core_sleep_o && wake) |=> !core_sleep_o
  ) else $error("core_sleep_o still high one cycle after a wake reason");

endmodule

`default_nettype wire

/* hw/sleep_timer.sv */
// Drain timer: counts consecutive enabled cycles and flags the sleep latency
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module sleep_timer (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  // High on each drained cycle in the drain state
  input  wire logic cnt_en_i,
  // Latency reached on this cycle
  output logic      lat_done_o
);

  import irq_pkg::*;

  // Last count before sleep may begin
  localparam sleep_cnt_t lat_last = sleep_cnt_t'(`SLEEP_LATENCY - 1);

  sleep_cnt_t cnt_q;

  // ------------------------------
  // Counter
  // ------------------------------
  // Any gap in the enable restarts the count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!cnt_en_i) begin
      cnt_q <= '0;
    end else if (!lat_done_o) begin
      cnt_q <= cnt_q + sleep_cnt_t'(1);
    end
    // Saturates at the last count, held while enabled
  end

  // First enabled cycle sees zero, so the flag rises on the SLEEP_LATENCY-th
  assign lat_done_o = (cnt_q == lat_last);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_irq_sleep \
  -o tb_irq_sleep || exit 1
./obj_dir/tb_irq_sleep > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

/* test/tb_irq_sleep.sv */
// Self-checking testbench for the interrupt and sleep controller, random traffic against a model
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module tb_irq_sleep;

  import irq_pkg::*;

  localparam irq_vec_t valid_mask = `IRQ_VALID_MASK;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic         clk_i;
  logic         rst_ni;
  irq_vec_t     irq_i;
  irq_vec_t     mie_i;
  priv_lvl_e    priv_lvl_i;
  logic         mstatus_mie_i;
  logic         wfi_i;
  logic         lsu_busy_i;
  outstanding_t outstanding_i;
  logic         debug_req_i;
  logic         nmi_pending_i;
  logic         core_sleep_o;
  logic         in_wfi_o;
  irq_vec_t     mip_o;
  logic         irq_ack_o;
  irq_id_t      irq_id_o;

  // Model state, advanced on every rising edge
  irq_vec_t     mip_m;
  logic         ack_m;
  irq_id_t      id_m;
  sleep_state_e st_m;
  sleep_cnt_t   cnt_m;

  // Stimulus controls, redrawn for each phase
  integer seed;
  int     irq_rate;
  int     busy_rate;
  int     evt_rate;

  irq_sleep_top i_irq_sleep_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .mstatus_mie_i (mstatus_mie_i),
    .wfi_i         (wfi_i),
    .lsu_busy_i    (lsu_busy_i),
    .outstanding_i (outstanding_i),
    .debug_req_i   (debug_req_i),
    .nmi_pending_i (nmi_pending_i),
    .core_sleep_o  (core_sleep_o),
    .in_wfi_o      (in_wfi_o),
    .mip_o         (mip_o),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("** Error: %s expected 0x%0h actual 0x%0h at %0t", name, exp_val, act_val, $time);
      $display("Verification failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Bit 5 flags a winner, bits 4..0 carry its id
  // Priority 31 down to 16, then 11, 3, 7
  function automatic logic [5:0] pick_winner(input irq_vec_t pe);
    logic [5:0] res;
    res = '0;
    for (int i = 31; i >= 16; i--) begin
      if (pe[i] && !res[5]) res = {1'b1, irq_id_t'(i)};
    end
    if (pe[11] && !res[5]) res = {1'b1, irq_id_t'(11)};
    if (pe[3] && !res[5]) res = {1'b1, irq_id_t'(3)};
    if (pe[7] && !res[5]) res = {1'b1, irq_id_t'(7)};
    return res;
  endfunction

  // Uses the inputs that were driven on the last falling edge
  task automatic model_update();
    irq_vec_t   pe;
    logic [5:0] win;
    logic       permit;
    logic       wake;
    logic       drained;
    logic       lat_done;
    logic       cnt_en;
    pe       = mip_m & mie_i;
    win      = pick_winner(pe);
    permit   = (priv_lvl_i == PRIV_M && mstatus_mie_i) || (priv_lvl_i == PRIV_U && pe != '0);
    wake     = (pe != '0) || debug_req_i || nmi_pending_i;
    drained  = (outstanding_i == '0) && !lsu_busy_i && !wake;
    lat_done = (cnt_m == sleep_cnt_t'(`SLEEP_LATENCY - 1));
    cnt_en   = (st_m == ST_DRAIN) && drained;
    // Ack never stays high two cycles in a row
    if (win[5] && permit && !ack_m) begin
      ack_m = 1'b1;
      id_m  = win[4:0];
    end else begin
      ack_m = 1'b0;
    end
    case (st_m)
      ST_RUN:   if (wfi_i) st_m = ST_DRAIN;
      ST_DRAIN: if (wake) st_m = ST_RUN; else if (drained && lat_done) st_m = ST_SLEEP;
      default:  if (wake) st_m = ST_RUN;
    endcase
    if (!cnt_en) cnt_m = '0;
    else if (!lat_done) cnt_m = cnt_m + sleep_cnt_t'(1);
    mip_m = irq_i & valid_mask;
  endtask

  task automatic compare_all();
    check_value("mip_o", mip_m, mip_o);
    check_value("irq_ack_o", 32'(ack_m), 32'(irq_ack_o));
    check_value("irq_id_o", 32'(id_m), 32'(irq_id_o));
    check_value("core_sleep_o", 32'(st_m == ST_SLEEP), 32'(core_sleep_o));
    check_value("in_wfi_o", 32'(st_m != ST_RUN), 32'(in_wfi_o));
  endtask

  // One clock cycle, outputs compared on the falling edge
  task automatic step();
    @(posedge clk_i);
    model_update();
    @(negedge clk_i);
    compare_all();
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic quiet_inputs();
    irq_i         = '0;
    wfi_i         = 1'b0;
    lsu_busy_i    = 1'b0;
    outstanding_i = '0;
    debug_req_i   = 1'b0;
    nmi_pending_i = 1'b0;
  endtask

  task automatic setup_phase();
    mie_i         = irq_vec_t'($random(seed) | $random(seed));
    priv_lvl_i    = ({$random(seed)} % 2 == 0) ? PRIV_M : PRIV_U;
    mstatus_mie_i = ({$random(seed)} % 2 == 0);
    irq_rate      = {$random(seed)} % 4;
    busy_rate     = {$random(seed)} % 3;
    evt_rate      = {$random(seed)} % 3;
  endtask

  // Sparse lines, rare wait strobes and wake events
  task automatic drive_random();
    irq_i = ({$random(seed)} % 8 < irq_rate) ?
            irq_vec_t'($random(seed) & $random(seed) & $random(seed)) : '0;
    wfi_i         = ({$random(seed)} % 16 == 0);
    lsu_busy_i    = ({$random(seed)} % 4 < busy_rate);
    outstanding_i = ({$random(seed)} % 4 < busy_rate) ? outstanding_t'($random(seed)) : '0;
    debug_req_i   = ({$random(seed)} % 64 < evt_rate);
    nmi_pending_i = ({$random(seed)} % 64 < evt_rate);
  endtask

  // Debug request forces the sequencer back to run, then pending drains
  task automatic wake_to_run();
    quiet_inputs();
    debug_req_i = 1'b1;
    step();
    debug_req_i = 1'b0;
    step();
    step();
  endtask

  // Wait strobe, then wait for sleep while counting drained cycles
  task automatic sleep_test(input int noisy);
    int n;
    int run;
    wake_to_run();
    wfi_i = 1'b1;
    step();
    wfi_i = 1'b0;
    n   = 1;
    run = 0;
    while (!core_sleep_o && n < 64) begin
      if (noisy != 0) begin
        lsu_busy_i    = ({$random(seed)} % 3 == 0);
        outstanding_i = ({$random(seed)} % 3 == 0) ? outstanding_t'(1) : '0;
      end
      if (in_wfi_o && !lsu_busy_i && outstanding_i == '0) run++;
      else run = 0;
      step();
      n++;
    end
    if (!core_sleep_o) begin
      $display("Timeout: core_sleep_o did not rise within 64 cycles after the wait strobe");
      $display("Verification failed");
      $fatal(1, "sleep entry timeout");
    end
    check_value("drained_run_at_sleep", `SLEEP_LATENCY, run);
    if (noisy == 0) check_value("sleep_entry_edges", 1 + `SLEEP_LATENCY, n);
    quiet_inputs();
  endtask

  // 0 debug, 1 NMI, 2 enabled interrupt
  task automatic wake_test(input int reason);
    if (reason == 2) begin
      mie_i = valid_mask;
      irq_i = irq_vec_t'(1) << 3;
      // Line reaches pending on this edge, sleep still held
      step();
      irq_i = '0;
      check_value("sleep_until_pending", 1, 32'(core_sleep_o));
    end else if (reason == 1) begin
      nmi_pending_i = 1'b1;
    end else begin
      debug_req_i = 1'b1;
    end
    step();
    check_value("wake_core_sleep", 0, 32'(core_sleep_o));
    check_value("wake_in_wfi", 0, 32'(in_wfi_o));
    quiet_inputs();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed          = 81174;
    rst_ni        = 1'b0;
    quiet_inputs();
    // Reset alone keeps the outputs low while lines and wait strobe are active
    irq_i         = '1;
    mie_i         = '1;
    priv_lvl_i    = PRIV_M;
    mstatus_mie_i = 1'b1;
    wfi_i         = 1'b1;
    mip_m = '0;
    ack_m = 1'b0;
    id_m  = '0;
    st_m  = ST_RUN;
    cnt_m = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset_irq_ack", 0, 32'(irq_ack_o));
    check_value("reset_irq_id", 0, 32'(irq_id_o));
    check_value("reset_core_sleep", 0, 32'(core_sleep_o));
    check_value("reset_in_wfi", 0, 32'(in_wfi_o));
    check_value("reset_mip", 0, mip_o);
    rst_ni = 1'b1;
    // Random traffic across privilege levels and enables
    for (int phase = 0; phase < 40; phase++) begin
      setup_phase();
      for (int c = 0; c < 50; c++) begin
        drive_random();
        step();
      end
    end
    // Directed sleep entry and each wake reason
    mie_i = valid_mask;
    for (int k = 0; k < 3; k++) begin
      sleep_test(0);
      wake_test(k);
      sleep_test(1);
      wake_test(k);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
